// ==== source/rob_pkg.sv ====
package rob_pkg;

  // datapath widths
  localparam int word_w    = 32;
  localparam int reg_idx_w = 5;
  localparam int func3_w   = 3;

  typedef logic [word_w-1:0]    word_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;
  // low two bits select the store width
  typedef logic [func3_w-1:0]   func3_t;

  // decoded instruction class
  typedef enum logic [2:0] {
    op_alu,
    op_load,
    op_store,
    op_branch,
    op_jal,
    op_jalr
  } op_e;

  // store width as seen by the memory port
  typedef enum logic [1:0] {
    len_byte = 2'd0,
    len_half = 2'd1,
    len_word = 2'd3
  } mem_len_e;

  typedef enum logic [1:0] {
    fs_idle,
    fs_fetching,
    fs_decoding,
    fs_predicting
  } fetch_state_e;

  typedef enum logic {
    cs_idle,
    cs_storing
  } commit_state_e;

  // static branch predictor, every branch guessed taken
  localparam logic predict_taken = 1'b1;

endpackage

// ==== source/fetch_sequencer.sv ====
`timescale 1ns/1ps

module fetch_sequencer import rob_pkg::*; #(
  parameter int DEPTH = 16,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic             clk,
  input  logic             rst,
  // fetch port
  output logic             fetch_req,
  input  logic             fetch_done,
  input  word_t            fetch_instr,
  input  word_t            fetch_pc,
  // decode port
  output logic             dec_req,
  output word_t            dec_instr,
  input  logic             dec_done,
  input  op_e              dec_op,
  input  reg_idx_t         dec_rd,
  input  reg_idx_t         dec_rs1,
  input  reg_idx_t         dec_rs2,
  input  func3_t           dec_func3,
  input  word_t            dec_imm,
  // next pc
  output logic             pc_write,
  output word_t            pc_write_val,
  // allocation toward the entry table
  output logic             alloc,
  output op_e              alloc_op,
  output reg_idx_t         alloc_rd,
  output reg_idx_t         alloc_rs1,
  output reg_idx_t         alloc_rs2,
  output func3_t           alloc_func3,
  output word_t            alloc_imm,
  output word_t            alloc_pc,
  input  logic [IDX_W-1:0] count,
  input  logic             flush
);

  fetch_state_e state;
  // pc and immediate of the instruction in flight
  word_t        cur_pc;
  word_t        cur_imm;
  logic         has_room;

  // one slot stays free so that head == tail means empty
  assign has_room = count < IDX_W'(DEPTH - 1);

  assign alloc       = (state == fs_decoding) && dec_done && !flush;
  assign alloc_op    = dec_op;
  assign alloc_rd    = dec_rd;
  assign alloc_rs1   = dec_rs1;
  assign alloc_rs2   = dec_rs2;
  assign alloc_func3 = dec_func3;
  assign alloc_imm   = dec_imm;
  assign alloc_pc    = cur_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= fs_idle;
      fetch_req <= 1'b0;
      dec_req   <= 1'b0;
      pc_write  <= 1'b0;
    end else begin
      fetch_req <= 1'b0;
      dec_req   <= 1'b0;
      pc_write  <= 1'b0;
      if (flush) begin
        // whatever was in flight is on the wrong path
        state <= fs_idle;
      end else begin
        case (state)
          fs_idle: begin
            if (has_room) begin
              fetch_req <= 1'b1;
              state     <= fs_fetching;
            end
          end
          fs_fetching: begin
            if (fetch_done) begin
              dec_req <= 1'b1;
              state   <= fs_decoding;
            end
          end
          fs_decoding: begin
            if (dec_done) begin
              if (dec_op == op_branch) begin
                state <= fs_predicting;
              end else begin
                pc_write <= 1'b1;
                state    <= fs_idle;
              end
            end
          end
          fs_predicting: begin
            pc_write <= 1'b1;
            state    <= fs_idle;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == fs_fetching && fetch_done) begin
      dec_instr <= fetch_instr;
      cur_pc    <= fetch_pc;
    end
    if (alloc) begin
      cur_imm      <= dec_imm;
      // jal target is known at decode, jalr is fixed up by a flush
      pc_write_val <= (dec_op == op_jal) ? cur_pc + dec_imm : cur_pc + 32'd4;
    end
    if (state == fs_predicting) begin
      pc_write_val <= predict_taken ? cur_pc + cur_imm : cur_pc + 32'd4;
    end
  end

  // responders only answer the request we are waiting on
  a_fetch_done_state: assert property (@(posedge clk) disable iff (rst)
    fetch_done |-> state == fs_fetching);
  a_dec_done_state: assert property (@(posedge clk) disable iff (rst)
    dec_done |-> state == fs_decoding);

endmodule

// ==== source/entry_table.sv ====
`timescale 1ns/1ps

module entry_table import rob_pkg::*; #(
  parameter int DEPTH = 16,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic             clk,
  input  logic             rst,
  // allocation
  input  logic             alloc,
  input  op_e              alloc_op,
  input  reg_idx_t         alloc_rd,
  input  reg_idx_t         alloc_rs1,
  input  reg_idx_t         alloc_rs2,
  input  func3_t           alloc_func3,
  input  word_t            alloc_imm,
  input  word_t            alloc_pc,
  output logic [IDX_W-1:0] count,
  // dispatch notice
  output logic             dispatch,
  output logic [IDX_W-1:0] dispatch_idx,
  output op_e              dispatch_op,
  output reg_idx_t         dispatch_rd,
  output reg_idx_t         dispatch_rs1,
  output reg_idx_t         dispatch_rs2,
  output word_t            dispatch_imm,
  output word_t            dispatch_pc,
  // writeback
  input  logic             wb,
  input  logic [IDX_W-1:0] wb_idx,
  input  word_t            wb_result,
  input  word_t            wb_tar_addr,
  input  logic             wb_broadcast,
  // common data bus
  output logic             cdb,
  output logic [IDX_W-1:0] cdb_idx,
  output word_t            cdb_value,
  // head entry
  output logic             head_ok,
  output logic [IDX_W-1:0] head_idx,
  output op_e              head_op,
  output reg_idx_t         head_rd,
  output func3_t           head_func3,
  output word_t            head_imm,
  output word_t            head_pc,
  output word_t            head_result,
  output word_t            head_tar_addr,
  // control
  input  logic             retire,
  input  logic             flush
);

  op_e              op_q     [DEPTH];
  reg_idx_t         rd_q     [DEPTH];
  func3_t           func3_q  [DEPTH];
  word_t            imm_q    [DEPTH];
  word_t            pc_q     [DEPTH];
  word_t            result_q [DEPTH];
  word_t            tar_q    [DEPTH];
  logic [DEPTH-1:0] ready_q;
  logic [DEPTH-1:0] bcast_q;
  logic [IDX_W-1:0] head_ptr;
  logic [IDX_W-1:0] tail_ptr;
  logic             pick_valid;
  logic [IDX_W-1:0] pick_idx;

  // pointers wrap naturally since DEPTH is a power of two
  assign count = tail_ptr - head_ptr;

  assign head_idx      = head_ptr;
  assign head_op       = op_q[head_ptr];
  assign head_rd       = rd_q[head_ptr];
  assign head_func3    = func3_q[head_ptr];
  assign head_imm      = imm_q[head_ptr];
  assign head_pc       = pc_q[head_ptr];
  assign head_result   = result_q[head_ptr];
  assign head_tar_addr = tar_q[head_ptr];
  // a pending broadcast has to go out before the head may retire
  assign head_ok = (head_ptr != tail_ptr) && ready_q[head_ptr] && !bcast_q[head_ptr];

  // oldest pending broadcast, scanning from head toward tail
  always_comb begin
    logic [IDX_W-1:0] idx;
    pick_valid = 1'b0;
    pick_idx   = head_ptr;
    for (int k = 0; k < DEPTH; k++) begin
      idx = head_ptr + IDX_W'(k);
      if (!pick_valid && IDX_W'(k) < count && bcast_q[idx]) begin
        pick_valid = 1'b1;
        pick_idx   = idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      ready_q  <= '0;
      bcast_q  <= '0;
      dispatch <= 1'b0;
      cdb      <= 1'b0;
    end else begin
      dispatch <= alloc;
      cdb      <= pick_valid;
      if (pick_valid) begin
        bcast_q[pick_idx] <= 1'b0;
      end
      if (wb) begin
        ready_q[wb_idx] <= 1'b1;
        // x0 results never go on the bus
        bcast_q[wb_idx] <= wb_broadcast && (rd_q[wb_idx] != '0);
      end
      if (alloc) begin
        ready_q[tail_ptr] <= 1'b0;
        bcast_q[tail_ptr] <= 1'b0;
        tail_ptr          <= tail_ptr + IDX_W'(1);
      end
      if (retire) begin
        head_ptr <= head_ptr + IDX_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      op_q[tail_ptr]    <= alloc_op;
      rd_q[tail_ptr]    <= alloc_rd;
      func3_q[tail_ptr] <= alloc_func3;
      imm_q[tail_ptr]   <= alloc_imm;
      pc_q[tail_ptr]    <= alloc_pc;
      dispatch_idx      <= tail_ptr;
      dispatch_op       <= alloc_op;
      dispatch_rd       <= alloc_rd;
      dispatch_rs1      <= alloc_rs1;
      dispatch_rs2      <= alloc_rs2;
      dispatch_imm      <= alloc_imm;
      dispatch_pc       <= alloc_pc;
    end
    if (wb) begin
      result_q[wb_idx] <= wb_result;
      tar_q[wb_idx]    <= wb_tar_addr;
    end
    if (pick_valid) begin
      cdb_idx   <= pick_idx;
      cdb_value <= result_q[pick_idx];
    end
  end

  a_wb_in_range: assert property (@(posedge clk) disable iff (rst)
    wb && !flush |-> IDX_W'(wb_idx - head_ptr) < count);
  // fetch side must hold off while the queue is full
  a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
    alloc |-> count != IDX_W'(DEPTH - 1));

endmodule

// ==== source/commit_unit.sv ====
`timescale 1ns/1ps

module commit_unit import rob_pkg::*; #(
  parameter int DEPTH = 16,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic             clk,
  input  logic             rst,
  // head entry
  input  logic             head_ok,
  input  logic [IDX_W-1:0] head_idx,
  input  op_e              head_op,
  input  reg_idx_t         head_rd,
  input  func3_t           head_func3,
  input  word_t            head_imm,
  input  word_t            head_pc,
  input  word_t            head_result,
  input  word_t            head_tar_addr,
  input  logic             mem_done,
  output logic             retire,
  // register commit
  output logic             reg_commit,
  output reg_idx_t         reg_commit_rd,
  output logic [IDX_W-1:0] reg_commit_tag,
  output word_t            reg_commit_value,
  // store
  output logic             mem_store,
  output word_t            mem_addr,
  output word_t            mem_data,
  output mem_len_e         mem_len,
  // flush
  output logic             flush,
  output word_t            flush_pc
);

  commit_state_e state;
  mem_len_e      store_len;
  logic          branch_taken;

  // no commit while a store is outstanding or during the flush cycle
  assign retire       = head_ok && (state == cs_idle) && !flush;
  // branch outcome is reported in bit 0 of the result
  assign branch_taken = head_result[0];

  always_comb begin
    case (head_func3[1:0])
      2'd0:    store_len = len_byte;
      2'd1:    store_len = len_half;
      default: store_len = len_word;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= cs_idle;
      reg_commit <= 1'b0;
      mem_store  <= 1'b0;
      flush      <= 1'b0;
    end else begin
      reg_commit <= 1'b0;
      mem_store  <= 1'b0;
      flush      <= 1'b0;
      if (state == cs_storing && mem_done) begin
        state <= cs_idle;
      end
      if (retire) begin
        case (head_op)
          op_store: begin
            mem_store <= 1'b1;
            state     <= cs_storing;
          end
          op_branch: begin
            flush <= (branch_taken != predict_taken);
          end
          default: begin
            reg_commit <= (head_rd != '0);
            flush      <= (head_op == op_jalr);
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (retire) begin
      reg_commit_rd    <= head_rd;
      reg_commit_tag   <= head_idx;
      reg_commit_value <= head_result;
      mem_addr         <= head_tar_addr;
      mem_data         <= head_result;
      mem_len          <= store_len;
      if (head_op == op_branch) begin
        flush_pc <= branch_taken ? head_pc + head_imm : head_pc + 32'd4;
      end else begin
        // jalr target from the execution unit
        flush_pc <= head_tar_addr;
      end
    end
  end

  // memory answers only the store we issued
  a_mem_done_storing: assert property (@(posedge clk) disable iff (rst)
    mem_done |-> state == cs_storing);

endmodule

// ==== source/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer import rob_pkg::*; #(
  parameter int DEPTH = 16,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic             clk,
  input  logic             rst,
  // instruction fetch
  output logic             fetch_req,
  input  logic             fetch_done,
  input  word_t            fetch_instr,
  input  word_t            fetch_pc,
  // decoder
  output logic             dec_req,
  output word_t            dec_instr,
  input  logic             dec_done,
  input  op_e              dec_op,
  input  reg_idx_t         dec_rd,
  input  reg_idx_t         dec_rs1,
  input  reg_idx_t         dec_rs2,
  input  func3_t           dec_func3,
  input  word_t            dec_imm,
  output logic             pc_write,
  output word_t            pc_write_val,
  // issue logic
  output logic             dispatch,
  output logic [IDX_W-1:0] dispatch_idx,
  output op_e              dispatch_op,
  output reg_idx_t         dispatch_rd,
  output reg_idx_t         dispatch_rs1,
  output reg_idx_t         dispatch_rs2,
  output word_t            dispatch_imm,
  output word_t            dispatch_pc,
  // execution writeback
  input  logic             wb,
  input  logic [IDX_W-1:0] wb_idx,
  input  word_t            wb_result,
  input  word_t            wb_tar_addr,
  input  logic             wb_broadcast,
  output logic             cdb,
  output logic [IDX_W-1:0] cdb_idx,
  output word_t            cdb_value,
  // architectural commit
  output logic             reg_commit,
  output reg_idx_t         reg_commit_rd,
  output logic [IDX_W-1:0] reg_commit_tag,
  output word_t            reg_commit_value,
  output logic             mem_store,
  output word_t            mem_addr,
  output word_t            mem_data,
  output mem_len_e         mem_len,
  input  logic             mem_done,
  output logic             flush,
  output word_t            flush_pc
);

  // fetch side to queue
  logic             alloc;
  op_e              alloc_op;
  reg_idx_t         alloc_rd;
  reg_idx_t         alloc_rs1;
  reg_idx_t         alloc_rs2;
  func3_t           alloc_func3;
  word_t            alloc_imm;
  word_t            alloc_pc;
  logic [IDX_W-1:0] count;

  // queue head to commit
  logic             head_ok;
  logic [IDX_W-1:0] head_idx;
  op_e              head_op;
  reg_idx_t         head_rd;
  func3_t           head_func3;
  word_t            head_imm;
  word_t            head_pc;
  word_t            head_result;
  word_t            head_tar_addr;
  logic             retire;

  // port names line up across the three units
  fetch_sequencer #(.DEPTH(DEPTH)) fetch_sequencer_inst (.*);

  entry_table #(.DEPTH(DEPTH)) entry_table_inst (.*);

  commit_unit #(.DEPTH(DEPTH)) commit_unit_inst (.*);

endmodule

// ==== tb/rob_checker.sv ====
`timescale 1ns/1ps

module rob_checker import rob_pkg::*; #(
  parameter int DEPTH = 8,
  parameter int ROWS = 20,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             fetch_req,
  input  logic             dec_req,
  input  word_t            dec_instr,
  input  logic             pc_write,
  input  word_t            pc_write_val,
  input  logic             dispatch,
  input  logic [IDX_W-1:0] dispatch_idx,
  input  op_e              dispatch_op,
  input  reg_idx_t         dispatch_rd,
  input  reg_idx_t         dispatch_rs1,
  input  reg_idx_t         dispatch_rs2,
  input  word_t            dispatch_imm,
  input  word_t            dispatch_pc,
  input  logic             wb,
  input  logic [IDX_W-1:0] wb_idx,
  input  word_t            wb_result,
  input  logic             wb_broadcast,
  input  logic             cdb,
  input  logic [IDX_W-1:0] cdb_idx,
  input  word_t            cdb_value,
  input  logic             reg_commit,
  input  reg_idx_t         reg_commit_rd,
  input  logic [IDX_W-1:0] reg_commit_tag,
  input  word_t            reg_commit_value,
  input  logic             mem_store,
  input  word_t            mem_addr,
  input  word_t            mem_data,
  input  mem_len_e         mem_len,
  input  logic             mem_done,
  input  logic             flush,
  input  word_t            flush_pc,
  input  op_e              t_op [ROWS],
  input  reg_idx_t         t_rd [ROWS],
  input  reg_idx_t         t_rs1 [ROWS],
  input  reg_idx_t         t_rs2 [ROWS],
  input  func3_t           t_func3 [ROWS],
  input  word_t            t_imm [ROWS],
  input  word_t            t_result [ROWS],
  input  word_t            t_tar [ROWS],
  output logic             done,
  output int               errors,
  output int               path_len
);

  // rows of the architectural path that give a commit strobe
  int               exp_rows[$];
  // rows dispatched since the last flush, oldest first
  int               live[$];
  int               slot_row [DEPTH];
  logic [DEPTH-1:0] pend;
  word_t            pend_val [DEPTH];
  int               ptr;
  int               max_live;
  int               tail_exp;
  logic             started;
  logic             store_wait;
  // pc the fetch side should be working on next
  word_t            fetch_exp;

  function automatic logic silent(int r);
    case (t_op[r])
      op_store:  return 1'b0;
      op_jalr:   return 1'b0;
      op_branch: return t_result[r][0];
      default:   return t_rd[r] == '0;
    endcase
  endfunction

  function automatic int next_row(int r);
    case (t_op[r])
      op_jal:    return r + int'(t_imm[r] >> 2);
      op_jalr:   return int'(t_tar[r] >> 2);
      op_branch: return t_result[r][0] ? r + int'(t_imm[r] >> 2) : r + 1;
      default:   return r + 1;
    endcase
  endfunction

  function automatic mem_len_e width_of(func3_t f3);
    case (f3[1:0])
      2'd0:    return len_byte;
      2'd1:    return len_half;
      default: return len_word;
    endcase
  endfunction

  task automatic check(string name, word_t got, word_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report(string msg);
    errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  task automatic build_path();
    int r;
    r = 0;
    while (r < ROWS) begin
      path_len++;
      if (!silent(r)) exp_rows.push_back(r);
      // a jump to itself ends the program
      if (t_op[r] == op_jal && t_imm[r] == '0) break;
      r = next_row(r);
    end
  endtask

  task automatic check_commit();
    int r;
    int k;
    logic exp_reg;
    logic exp_fl;
    word_t exp_pc;
    r = exp_rows[ptr];
    ptr++;
    exp_reg = (t_op[r] inside {op_alu, op_load, op_jal, op_jalr}) && t_rd[r] != '0;
    exp_fl  = t_op[r] == op_jalr || (t_op[r] == op_branch && !t_result[r][0]);
    if (reg_commit !== exp_reg || mem_store !== (t_op[r] == op_store) || flush !== exp_fl)
      report($sformatf("wrong kind of commit for program row %0d", r));
    if (reg_commit) begin
      check("reg_commit_rd", word_t'(reg_commit_rd), word_t'(t_rd[r]));
      check("reg_commit_value", reg_commit_value, t_result[r]);
      check("reg_commit_tag row", word_t'(slot_row[reg_commit_tag]), word_t'(r));
      if (pend[reg_commit_tag]) report("register commit came before its broadcast");
    end
    if (mem_store) begin
      check("mem_addr", mem_addr, t_tar[r]);
      check("mem_data", mem_data, t_result[r]);
      check("mem_len", word_t'(mem_len), word_t'(width_of(t_func3[r])));
      store_wait = 1'b1;
    end
    if (exp_fl) begin
      exp_pc = t_op[r] == op_branch ? word_t'(r * 4 + 4) : t_tar[r];
      if (flush) check("flush_pc", flush_pc, exp_pc);
      // fetch resumes at the corrected target
      fetch_exp = exp_pc;
    end
    // everything up to the committed row has left the queue
    while (live.size() > 0) begin
      k = live.pop_front();
      if (k == r) break;
    end
  endtask

  task automatic sample();
    int r;
    int n;
    int k;
    if (!started) begin
      if (dec_req || pc_write || dispatch || cdb || reg_commit || mem_store || flush)
        report("a strobe rose before the first fetch request");
      if (fetch_req) started = 1'b1;
    end
    if (dec_req) check("dec_instr", dec_instr, fetch_exp);
    if (dispatch) begin
      r = int'(fetch_exp >> 2);
      check("dispatch_pc", dispatch_pc, fetch_exp);
      check("dispatch_idx", word_t'(dispatch_idx), word_t'(tail_exp));
      check("dispatch_op", word_t'(dispatch_op), word_t'(t_op[r]));
      check("dispatch_rd", word_t'(dispatch_rd), word_t'(t_rd[r]));
      check("dispatch_rs1", word_t'(dispatch_rs1), word_t'(t_rs1[r]));
      check("dispatch_rs2", word_t'(dispatch_rs2), word_t'(t_rs2[r]));
      check("dispatch_imm", dispatch_imm, t_imm[r]);
      slot_row[dispatch_idx] = r;
      tail_exp = (tail_exp + 1) % DEPTH;
      // static prediction, jal and every branch go to pc+imm
      if (t_op[r] == op_jal || t_op[r] == op_branch)
        fetch_exp = fetch_exp + t_imm[r];
      else
        fetch_exp = fetch_exp + 32'd4;
      live.push_back(r);
      n = live.size();
      k = 0;
      while (k < n && silent(live[k])) k++;
      if (n - k > DEPTH - 1) report("more entries in flight than the queue can hold");
      if (n - k > max_live) max_live = n - k;
    end
    if (pc_write) check("pc_write_val", pc_write_val, fetch_exp);
    if (cdb) begin
      if (!pend[cdb_idx]) report("broadcast without a pending writeback");
      else check("cdb_value", cdb_value, pend_val[cdb_idx]);
      pend[cdb_idx] = 1'b0;
    end
    if (wb) begin
      pend[wb_idx] = wb_broadcast && t_rd[slot_row[wb_idx]] != '0;
      pend_val[wb_idx] = wb_result;
    end
    if (reg_commit || mem_store || flush) begin
      if (store_wait) report("commit while a store was still outstanding");
      if (ptr >= exp_rows.size()) report("commit past the end of the program path");
      else check_commit();
    end
    if (flush) begin
      live.delete();
      pend = '0;
      tail_exp = 0;
    end
    if (mem_done) begin
      if (!store_wait && !mem_store) report("mem_done without a store");
      store_wait = 1'b0;
    end
    if (!done && started && ptr == exp_rows.size() && !store_wait) begin
      done = 1'b1;
      if (max_live != DEPTH - 1) report("the queue was never filled");
    end
  endtask

  initial begin
    done = 1'b0;
    errors = 0;
    path_len = 0;
    ptr = 0;
    max_live = 0;
    tail_exp = 0;
    started = 1'b0;
    store_wait = 1'b0;
    fetch_exp = '0;
    pend = '0;
    @(negedge rst);
    build_path();
    forever begin
      @(negedge clk);
      sample();
    end
  end

endmodule

// ==== tb/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb import rob_pkg::*; ();

  localparam int DEPTH = 8;
  localparam int ROWS = 20;
  localparam int IDX_W = $clog2(DEPTH);

  logic clk, rst;
  logic fetch_req, fetch_done, dec_req, dec_done, pc_write;
  word_t fetch_instr, fetch_pc, dec_instr, dec_imm, pc_write_val;
  op_e dec_op, dispatch_op;
  reg_idx_t dec_rd, dec_rs1, dec_rs2;
  func3_t dec_func3;
  logic dispatch, wb, wb_broadcast, cdb;
  logic [IDX_W-1:0] dispatch_idx, wb_idx, cdb_idx, reg_commit_tag;
  reg_idx_t dispatch_rd, dispatch_rs1, dispatch_rs2, reg_commit_rd;
  word_t dispatch_imm, dispatch_pc, wb_result, wb_tar_addr, cdb_value;
  logic reg_commit, mem_store, mem_done, flush;
  word_t reg_commit_value, mem_addr, mem_data, flush_pc;
  mem_len_e mem_len;

  // program table, the row for pc p is p/4
  op_e t_op [ROWS];
  reg_idx_t t_rd [ROWS];
  reg_idx_t t_rs1 [ROWS];
  reg_idx_t t_rs2 [ROWS];
  func3_t t_func3 [ROWS];
  word_t t_imm [ROWS];
  word_t t_result [ROWS];
  word_t t_tar [ROWS];
  logic t_bc [ROWS];

  logic done;
  int errors, path_len;
  int cycle, limit, settle, dec_row;
  int fetch_wait, dec_wait, mem_wait, outstanding;
  logic fetch_busy, dec_busy, mem_busy, hold;
  word_t pc, fetch_addr;
  logic [31:0] rng;
  // execution model, one entry per dispatched instruction
  int exec_idx[$], exec_row[$], exec_due[$];

  reorder_buffer #(.DEPTH(DEPTH)) reorder_buffer_inst (.*);

  rob_checker #(.DEPTH(DEPTH), .ROWS(ROWS)) rob_checker_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int rand_delay();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return int'(rng % 6);
  endfunction

  task automatic set_row(int r, op_e op, int rd, word_t imm, word_t res, word_t tar,
                         int f3, logic bc);
    t_op[r] = op;
    t_rd[r] = reg_idx_t'(rd);
    t_rs1[r] = reg_idx_t'(r);
    t_rs2[r] = reg_idx_t'(r + 1);
    t_func3[r] = func3_t'(f3);
    t_imm[r] = imm;
    t_result[r] = res;
    t_tar[r] = tar;
    t_bc[r] = bc;
  endtask

  task automatic load_program();
    set_row(0, op_alu, 1, 0, 32'h11, 0, 0, 1);
    set_row(1, op_alu, 2, 0, 32'h22, 0, 0, 0);
    set_row(2, op_load, 3, 0, 32'h33, 0, 2, 1);
    set_row(3, op_alu, 4, 0, 32'h44, 0, 0, 1);
    set_row(4, op_alu, 0, 0, 32'h5, 0, 0, 1);
    set_row(5, op_alu, 5, 0, 32'h55, 0, 0, 1);
    set_row(6, op_store, 0, 0, 32'haa, 32'h100, 0, 0);
    set_row(7, op_alu, 6, 0, 32'h66, 0, 0, 1);
    // taken branch, skips row 9
    set_row(8, op_branch, 0, 8, 32'h1, 0, 0, 0);
    set_row(9, op_alu, 7, 0, 32'h77, 0, 0, 1);
    set_row(10, op_store, 0, 0, 32'hbbbb, 32'h104, 1, 0);
    // not taken, so predicting taken flushes back to row 12
    set_row(11, op_branch, 0, 12, 32'h0, 0, 0, 0);
    set_row(12, op_alu, 8, 0, 32'h88, 0, 0, 1);
    set_row(13, op_jal, 9, 12, 32'h38, 0, 0, 1);
    set_row(14, op_alu, 10, 0, 32'ha0, 0, 0, 1);
    set_row(15, op_alu, 11, 0, 32'hb0, 0, 0, 1);
    set_row(16, op_store, 0, 0, 32'hcccc, 32'h108, 2, 0);
    set_row(17, op_jalr, 12, 0, 32'h48, 32'h4c, 0, 1);
    set_row(18, op_alu, 13, 0, 32'hd0, 0, 0, 1);
    // jump to itself, end of program
    set_row(19, op_jal, 0, 0, 32'h0, 0, 0, 0);
  endtask

  task automatic serve_cycle();
    int k;
    int r;
    fetch_done = 1'b0;
    dec_done = 1'b0;
    wb = 1'b0;
    mem_done = 1'b0;
    if (flush) begin
      // wrong-path requests die with the flush
      pc = flush_pc;
      fetch_busy = 1'b0;
      dec_busy = 1'b0;
      exec_idx.delete();
      exec_row.delete();
      exec_due.delete();
      return;
    end
    if (pc_write) pc = pc_write_val;
    if (fetch_req) begin
      fetch_busy = 1'b1;
      fetch_addr = pc;
      fetch_wait = rand_delay();
    end
    if (dec_req) begin
      dec_busy = 1'b1;
      dec_row = int'(dec_instr >> 2);
      if (dec_row >= ROWS) dec_row = ROWS - 1;
      dec_wait = rand_delay();
    end
    if (dispatch) begin
      exec_idx.push_back(int'(dispatch_idx));
      exec_row.push_back(int'(dispatch_pc >> 2));
      exec_due.push_back(cycle + rand_delay());
      outstanding++;
      // release writebacks once the queue is full
      if (outstanding >= DEPTH - 1) hold = 1'b0;
    end
    if (mem_store) begin
      mem_busy = 1'b1;
      mem_wait = rand_delay();
    end
    if (fetch_busy) begin
      if (fetch_wait == 0) begin
        fetch_done = 1'b1;
        fetch_pc = fetch_addr;
        fetch_instr = fetch_addr;
        fetch_busy = 1'b0;
      end else fetch_wait--;
    end
    if (dec_busy) begin
      if (dec_wait == 0) begin
        dec_done = 1'b1;
        dec_op = t_op[dec_row];
        dec_rd = t_rd[dec_row];
        dec_rs1 = t_rs1[dec_row];
        dec_rs2 = t_rs2[dec_row];
        dec_func3 = t_func3[dec_row];
        dec_imm = t_imm[dec_row];
        dec_busy = 1'b0;
      end else dec_wait--;
    end
    if (cycle > 300) hold = 1'b0;
    k = 0;
    while (!hold && !wb && k < exec_idx.size()) begin
      if (exec_due[k] <= cycle) begin
        r = exec_row[k];
        wb = 1'b1;
        wb_idx = IDX_W'(exec_idx[k]);
        wb_result = t_result[r];
        wb_tar_addr = t_tar[r];
        wb_broadcast = t_bc[r];
        exec_idx.delete(k);
        exec_row.delete(k);
        exec_due.delete(k);
      end else k++;
    end
    if (mem_busy) begin
      if (mem_wait == 0) begin
        mem_done = 1'b1;
        mem_busy = 1'b0;
      end else mem_wait--;
    end
  endtask

  initial begin
    rst = 1'b1;
    fetch_done = 1'b0;
    fetch_instr = '0;
    fetch_pc = '0;
    dec_done = 1'b0;
    dec_op = op_alu;
    dec_rd = '0;
    dec_rs1 = '0;
    dec_rs2 = '0;
    dec_func3 = '0;
    dec_imm = '0;
    wb = 1'b0;
    wb_idx = '0;
    wb_result = '0;
    wb_tar_addr = '0;
    wb_broadcast = 1'b0;
    mem_done = 1'b0;
    rng = 32'h9d1;
    pc = '0;
    fetch_busy = 1'b0;
    dec_busy = 1'b0;
    mem_busy = 1'b0;
    hold = 1'b1;
    outstanding = 0;
    cycle = 0;
    settle = 0;
    load_program();
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    limit = path_len * 40 + 200;
    // a few extra cycles after the last commit catch stray strobes
    while (settle < 20 && cycle < limit) begin
      @(posedge clk);
      #1;
      cycle++;
      if (done) settle++;
      serve_cycle();
    end
    if (!done) $display("timeout: commit stream incomplete after %0d cycles", cycle);
    $display("checker errors: %0d", errors);
    if (done && errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
source/rob_pkg.sv
source/fetch_sequencer.sv
source/entry_table.sv
source/commit_unit.sv
source/reorder_buffer.sv
tb/rob_checker.sv
tb/rob_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module rob_tb \
  -Mdir obj_dir -o rob_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/rob_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1
